/* verilog/rs_pkg.sv */
package rs_pkg;

    localparam int DATA_W    = 32;
    localparam int PREG_W    = 5;
    localparam int NUM_PREGS = 1 << PREG_W;

    typedef logic [DATA_W-1:0] t_data;
    typedef logic [PREG_W-1:0] t_preg;

    typedef enum logic [2:0] {
        UOP_ADD = 3'd0,
        UOP_SUB = 3'd1,
        UOP_AND = 3'd2,
        UOP_XOR = 3'd3,
        UOP_SLL = 3'd4,
        UOP_MUL = 3'd5
    } t_uop;

    // Where a source operand comes from
    typedef enum logic [1:0] {
        OP_ZERO = 2'd0,
        OP_IMM  = 2'd1,
        OP_REG  = 2'd2
    } t_optype;

    typedef enum logic {
        FU_ALU = 1'b0,
        FU_MUL = 1'b1
    } t_fu;

    // Unit steering, shared by the station and the testbench
    function automatic t_fu uop_to_fu(t_uop uop);
        t_fu fu;
        case (uop)
            UOP_MUL: fu = FU_MUL;
            default: fu = FU_ALU;
        endcase
        return fu;
    endfunction

endpackage

/* verilog/rs_entry.sv */
`timescale 1ns/1ps

module rs_entry
    import rs_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    flush,

    input  logic    alloc,
    input  t_uop    alloc_uop,
    input  t_optype alloc_src1_type,
    input  t_optype alloc_src2_type,
    input  t_preg   alloc_psrc1,
    input  t_preg   alloc_psrc2,
    input  t_data   alloc_imm,
    input  t_preg   alloc_pdst,
    input  logic    alloc_ready1,
    input  logic    alloc_ready2,

    input  logic    alu_wr_en,
    input  t_preg   alu_wr_preg,
    input  logic    mul_wr_en,
    input  t_preg   mul_wr_preg,

    input  logic    gnt,
    output logic    valid,
    output logic    req,

    output t_uop    uop,
    output t_optype src1_type,
    output t_optype src2_type,
    output t_preg   psrc1,
    output t_preg   psrc2,
    output t_data   imm,
    output t_preg   pdst
);

    logic rdy1;
    logic rdy2;
    logic wake1;
    logic wake2;

    // Wakeup from either write port
    assign wake1 = (alu_wr_en && alu_wr_preg == psrc1) || (mul_wr_en && mul_wr_preg == psrc1);
    assign wake2 = (alu_wr_en && alu_wr_preg == psrc2) || (mul_wr_en && mul_wr_preg == psrc2);

    assign req = valid && rdy1 && rdy2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
            rdy1  <= 1'b0;
            rdy2  <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (alloc) begin
            valid <= 1'b1;
            // Non-register sources are ready at once
            rdy1  <= (alloc_src1_type != OP_REG) || alloc_ready1;
            rdy2  <= (alloc_src2_type != OP_REG) || alloc_ready2;
        end else begin
            if (gnt) begin
                valid <= 1'b0;
            end
            if (wake1) begin
                rdy1 <= 1'b1;
            end
            if (wake2) begin
                rdy2 <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            uop       <= alloc_uop;
            src1_type <= alloc_src1_type;
            src2_type <= alloc_src2_type;
            psrc1     <= alloc_psrc1;
            psrc2     <= alloc_psrc2;
            imm       <= alloc_imm;
            pdst      <= alloc_pdst;
        end
    end

    a_alloc_free: assert property (@(posedge clk) disable iff (!rst_n)
        alloc |-> !valid);

endmodule

/* verilog/rs.sv */
`timescale 1ns/1ps

module rs
    import rs_pkg::*;
#(
    parameter int NUM_RS_ENTS = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,

    input  logic       disp_valid,
    input  t_uop       disp_uop,
    input  t_optype    disp_src1_type,
    input  t_optype    disp_src2_type,
    input  t_preg      disp_psrc1,
    input  t_preg      disp_psrc2,
    input  t_data      disp_imm,
    input  t_preg      disp_pdst,
    output logic       rs_stall,

    output t_preg      sb_rdaddr1,
    output t_preg      sb_rdaddr2,
    input  logic       sb_ready1,
    input  logic       sb_ready2,
    output logic       sb_set_busy,
    output t_preg      sb_busy_preg,

    output logic [1:0] prf_rden,
    output t_preg      prf_rdaddr [1:0],
    input  t_data      prf_rddata [1:0],

    input  logic       alu_wr_en,
    input  t_preg      alu_wr_preg,
    input  logic       mul_wr_en,
    input  t_preg      mul_wr_preg,

    output logic       alu_iss,
    output logic       mul_iss,
    output t_uop       iss_uop,
    output t_preg      iss_pdst,
    output t_data      iss_src1_val,
    output t_data      iss_src2_val
);

    logic                   accept;
    logic [NUM_RS_ENTS-1:0] e_alloc;
    logic [NUM_RS_ENTS-1:0] e_valid;
    logic [NUM_RS_ENTS-1:0] e_req;
    logic [NUM_RS_ENTS-1:0] e_sel;
    logic [NUM_RS_ENTS-1:0] e_gnt;
    t_uop                   e_uop       [NUM_RS_ENTS];
    t_optype                e_src1_type [NUM_RS_ENTS];
    t_optype                e_src2_type [NUM_RS_ENTS];
    t_preg                  e_psrc1     [NUM_RS_ENTS];
    t_preg                  e_psrc2     [NUM_RS_ENTS];
    t_data                  e_imm       [NUM_RS_ENTS];
    t_preg                  e_pdst      [NUM_RS_ENTS];

    logic    any_req;
    logic    iss_rs1;
    t_uop    sel_uop;
    t_optype sel_src1_type;
    t_optype sel_src2_type;
    t_data   sel_imm;
    t_preg   sel_pdst;

    logic    iss_nq_rs2;
    logic    iss_rs2;
    t_uop    uop_rs2;
    t_optype src1_type_rs2;
    t_optype src2_type_rs2;
    t_data   imm_rs2;
    t_preg   pdst_rs2;

    assign rs_stall = &e_valid;
    assign accept   = disp_valid && !rs_stall;

    // First free entry
    always_comb begin
        e_alloc = '0;
        for (int i = 0; i < NUM_RS_ENTS; i++) begin
            if (!e_valid[i] && e_alloc == '0) begin
                e_alloc[i] = accept;
            end
        end
    end

    assign sb_rdaddr1   = disp_psrc1;
    assign sb_rdaddr2   = disp_psrc2;
    assign sb_set_busy  = accept;
    assign sb_busy_preg = disp_pdst;

    // Lowest-indexed requester wins
    always_comb begin
        any_req       = 1'b0;
        e_sel         = '0;
        sel_uop       = UOP_ADD;
        sel_src1_type = OP_ZERO;
        sel_src2_type = OP_ZERO;
        sel_imm       = '0;
        sel_pdst      = '0;
        prf_rdaddr[0] = '0;
        prf_rdaddr[1] = '0;
        for (int i = 0; i < NUM_RS_ENTS; i++) begin
            if (e_req[i] && !any_req) begin
                any_req       = 1'b1;
                e_sel[i]      = 1'b1;
                sel_uop       = e_uop[i];
                sel_src1_type = e_src1_type[i];
                sel_src2_type = e_src2_type[i];
                sel_imm       = e_imm[i];
                sel_pdst      = e_pdst[i];
                prf_rdaddr[0] = e_psrc1[i];
                prf_rdaddr[1] = e_psrc2[i];
            end
        end
    end

    assign iss_rs1 = any_req && !flush;
    assign e_gnt   = iss_rs1 ? e_sel : '0;

    assign prf_rden[0] = iss_rs1 && sel_src1_type == OP_REG;
    assign prf_rden[1] = iss_rs1 && sel_src2_type == OP_REG;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            iss_nq_rs2 <= 1'b0;
        end else begin
            iss_nq_rs2 <= iss_rs1;
        end
    end

    always_ff @(posedge clk) begin
        uop_rs2       <= sel_uop;
        src1_type_rs2 <= sel_src1_type;
        src2_type_rs2 <= sel_src2_type;
        imm_rs2       <= sel_imm;
        pdst_rs2      <= sel_pdst;
    end

    function automatic t_data f_opsel(t_optype optype, t_data imm_data, t_data prf_data);
        t_data val;
        case (optype)
            OP_IMM:  val = imm_data;
            OP_REG:  val = prf_data;
            default: val = '0;
        endcase
        return val;
    endfunction

    // Flush kills the issue already in rs2
    assign iss_rs2 = iss_nq_rs2 && !flush;

    assign iss_uop      = uop_rs2;
    assign iss_pdst     = pdst_rs2;
    assign iss_src1_val = f_opsel(src1_type_rs2, imm_rs2, prf_rddata[0]);
    assign iss_src2_val = f_opsel(src2_type_rs2, imm_rs2, prf_rddata[1]);

    assign alu_iss = iss_rs2 && uop_to_fu(uop_rs2) == FU_ALU;
    assign mul_iss = iss_rs2 && uop_to_fu(uop_rs2) == FU_MUL;

    for (genvar i = 0; i < NUM_RS_ENTS; i++) begin : g_entries
        rs_entry entry (
            .clk             (clk),
            .rst_n           (rst_n),
            .flush           (flush),
            .alloc           (e_alloc[i]),
            .alloc_uop       (disp_uop),
            .alloc_src1_type (disp_src1_type),
            .alloc_src2_type (disp_src2_type),
            .alloc_psrc1     (disp_psrc1),
            .alloc_psrc2     (disp_psrc2),
            .alloc_imm       (disp_imm),
            .alloc_pdst      (disp_pdst),
            .alloc_ready1    (sb_ready1),
            .alloc_ready2    (sb_ready2),
            .alu_wr_en       (alu_wr_en),
            .alu_wr_preg     (alu_wr_preg),
            .mul_wr_en       (mul_wr_en),
            .mul_wr_preg     (mul_wr_preg),
            .gnt             (e_gnt[i]),
            .valid           (e_valid[i]),
            .req             (e_req[i]),
            .uop             (e_uop[i]),
            .src1_type       (e_src1_type[i]),
            .src2_type       (e_src2_type[i]),
            .psrc1           (e_psrc1[i]),
            .psrc2           (e_psrc2[i]),
            .imm             (e_imm[i]),
            .pdst            (e_pdst[i])
        );
    end

    a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(e_gnt));

    a_iss_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_iss && mul_iss));

endmodule

/* verilog/prf.sv */
`timescale 1ns/1ps

module prf
    import rs_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic [1:0] prf_rden,
    input  t_preg      prf_rdaddr [1:0],
    output t_data      prf_rddata [1:0],

    input  logic       alu_wr_en,
    input  t_preg      alu_wr_preg,
    input  t_data      alu_wr_data,
    input  logic       mul_wr_en,
    input  t_preg      mul_wr_preg,
    input  t_data      mul_wr_data,

    input  t_preg      sb_rdaddr1,
    input  t_preg      sb_rdaddr2,
    output logic       sb_ready1,
    output logic       sb_ready2,
    input  logic       sb_set_busy,
    input  t_preg      sb_busy_preg
);

    t_data                regs [NUM_PREGS];
    logic [NUM_PREGS-1:0] ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
            ready <= '1;
        end else begin
            if (alu_wr_en) begin
                regs[alu_wr_preg]  <= alu_wr_data;
                ready[alu_wr_preg] <= 1'b1;
            end
            if (mul_wr_en) begin
                regs[mul_wr_preg]  <= mul_wr_data;
                ready[mul_wr_preg] <= 1'b1;
            end
            // New destination waits for its producer
            if (sb_set_busy) begin
                ready[sb_busy_preg] <= 1'b0;
            end
        end
    end

    // Registered read, data lands in rs2
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (prf_rden[p]) begin
                prf_rddata[p] <= regs[prf_rdaddr[p]];
            end
        end
    end

    // Forward same-cycle writes so dispatch sees the wakeup
    assign sb_ready1 = ready[sb_rdaddr1] ||
                       (alu_wr_en && alu_wr_preg == sb_rdaddr1) ||
                       (mul_wr_en && mul_wr_preg == sb_rdaddr1);
    assign sb_ready2 = ready[sb_rdaddr2] ||
                       (alu_wr_en && alu_wr_preg == sb_rdaddr2) ||
                       (mul_wr_en && mul_wr_preg == sb_rdaddr2);

    a_wr_conflict: assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_wr_en && mul_wr_en && alu_wr_preg == mul_wr_preg));

endmodule

/* verilog/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit
    import rs_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    input  logic  iss,
    input  t_uop  iss_uop,
    input  t_preg iss_pdst,
    input  t_data iss_src1_val,
    input  t_data iss_src2_val,

    output logic  wr_en,
    output t_preg wr_preg,
    output t_data wr_data
);

    t_data result;

    always_comb begin
        case (iss_uop)
            UOP_ADD: result = iss_src1_val + iss_src2_val;
            UOP_SUB: result = iss_src1_val - iss_src2_val;
            UOP_AND: result = iss_src1_val & iss_src2_val;
            UOP_XOR: result = iss_src1_val ^ iss_src2_val;
            // Shift amount from low five bits only
            UOP_SLL: result = iss_src1_val << iss_src2_val[4:0];
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= iss;
        end
    end

    always_ff @(posedge clk) begin
        if (iss) begin
            wr_preg <= iss_pdst;
            wr_data <= result;
        end
    end

endmodule

/* verilog/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit
    import rs_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    input  logic  iss,
    input  t_uop  iss_uop,
    input  t_preg iss_pdst,
    input  t_data iss_src1_val,
    input  t_data iss_src2_val,

    output logic  wr_en,
    output t_preg wr_preg,
    output t_data wr_data
);

    logic        vld_s1;
    t_preg       pdst_s1;
    t_data       lo_part;
    logic [15:0] hi_part;
    t_data       lo_s1;
    logic [15:0] hi_s1;

    // Partial products, only the low 32 bits survive
    assign lo_part = iss_src1_val[15:0] * iss_src2_val;
    assign hi_part = iss_src1_val[31:16] * iss_src2_val[15:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_s1 <= 1'b0;
            wr_en  <= 1'b0;
        end else begin
            vld_s1 <= iss && iss_uop == UOP_MUL;
            wr_en  <= vld_s1;
        end
    end

    always_ff @(posedge clk) begin
        pdst_s1 <= iss_pdst;
        lo_s1   <= lo_part;
        hi_s1   <= hi_part;
        // Second stage sums the partials
        wr_preg <= pdst_s1;
        wr_data <= lo_s1 + {hi_s1, 16'h0000};
    end

endmodule

/* verilog/issue_top.sv */
`timescale 1ns/1ps

module issue_top
    import rs_pkg::*;
#(
    parameter int NUM_RS_ENTS = 8
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    flush,

    input  logic    disp_valid,
    input  t_uop    disp_uop,
    input  t_optype disp_src1_type,
    input  t_optype disp_src2_type,
    input  t_preg   disp_psrc1,
    input  t_preg   disp_psrc2,
    input  t_data   disp_imm,
    input  t_preg   disp_pdst,
    output logic    rs_stall,

    output logic    alu_wr_en,
    output t_preg   alu_wr_preg,
    output t_data   alu_wr_data,
    output logic    mul_wr_en,
    output t_preg   mul_wr_preg,
    output t_data   mul_wr_data
);

    t_preg      sb_rdaddr1;
    t_preg      sb_rdaddr2;
    logic       sb_ready1;
    logic       sb_ready2;
    logic       sb_set_busy;
    t_preg      sb_busy_preg;
    logic [1:0] prf_rden;
    t_preg      prf_rdaddr [1:0];
    t_data      prf_rddata [1:0];
    logic       alu_iss;
    logic       mul_iss;
    t_uop       iss_uop;
    t_preg      iss_pdst;
    t_data      iss_src1_val;
    t_data      iss_src2_val;

    rs #(
        .NUM_RS_ENTS (NUM_RS_ENTS)
    ) rs0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .disp_valid     (disp_valid),
        .disp_uop       (disp_uop),
        .disp_src1_type (disp_src1_type),
        .disp_src2_type (disp_src2_type),
        .disp_psrc1     (disp_psrc1),
        .disp_psrc2     (disp_psrc2),
        .disp_imm       (disp_imm),
        .disp_pdst      (disp_pdst),
        .rs_stall       (rs_stall),
        .sb_rdaddr1     (sb_rdaddr1),
        .sb_rdaddr2     (sb_rdaddr2),
        .sb_ready1      (sb_ready1),
        .sb_ready2      (sb_ready2),
        .sb_set_busy    (sb_set_busy),
        .sb_busy_preg   (sb_busy_preg),
        .prf_rden       (prf_rden),
        .prf_rdaddr     (prf_rdaddr),
        .prf_rddata     (prf_rddata),
        .alu_wr_en      (alu_wr_en),
        .alu_wr_preg    (alu_wr_preg),
        .mul_wr_en      (mul_wr_en),
        .mul_wr_preg    (mul_wr_preg),
        .alu_iss        (alu_iss),
        .mul_iss        (mul_iss),
        .iss_uop        (iss_uop),
        .iss_pdst       (iss_pdst),
        .iss_src1_val   (iss_src1_val),
        .iss_src2_val   (iss_src2_val)
    );

    prf prf0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .prf_rden     (prf_rden),
        .prf_rdaddr   (prf_rdaddr),
        .prf_rddata   (prf_rddata),
        .alu_wr_en    (alu_wr_en),
        .alu_wr_preg  (alu_wr_preg),
        .alu_wr_data  (alu_wr_data),
        .mul_wr_en    (mul_wr_en),
        .mul_wr_preg  (mul_wr_preg),
        .mul_wr_data  (mul_wr_data),
        .sb_rdaddr1   (sb_rdaddr1),
        .sb_rdaddr2   (sb_rdaddr2),
        .sb_ready1    (sb_ready1),
        .sb_ready2    (sb_ready2),
        .sb_set_busy  (sb_set_busy),
        .sb_busy_preg (sb_busy_preg)
    );

    alu_unit alu0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .iss          (alu_iss),
        .iss_uop      (iss_uop),
        .iss_pdst     (iss_pdst),
        .iss_src1_val (iss_src1_val),
        .iss_src2_val (iss_src2_val),
        .wr_en        (alu_wr_en),
        .wr_preg      (alu_wr_preg),
        .wr_data      (alu_wr_data)
    );

    mul_unit mul0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .iss          (mul_iss),
        .iss_uop      (iss_uop),
        .iss_pdst     (iss_pdst),
        .iss_src1_val (iss_src1_val),
        .iss_src2_val (iss_src2_val),
        .wr_en        (mul_wr_en),
        .wr_preg      (mul_wr_preg),
        .wr_data      (mul_wr_data)
    );

endmodule

/* test/rs_tb.sv */
`timescale 1ns/1ps

module rs_tb
    import rs_pkg::*;
();

    localparam int NUM_ENTS   = 8;
    localparam int NUM_ARCH   = 8;
    localparam int TIMEOUT    = 200;
    localparam int STALL_TEST = 4;

    // Row classes
    localparam int CLS_EXEC   = 0;
    localparam int CLS_ORPHAN = 1;
    localparam int CLS_WAIT   = 2;
    localparam int CLS_FLUSH  = 3;
    localparam int CLS_REVIVE = 4;

    logic    clk;
    logic    rst_n;
    logic    flush;
    logic    disp_valid;
    t_uop    disp_uop;
    t_optype disp_src1_type;
    t_optype disp_src2_type;
    t_preg   disp_psrc1;
    t_preg   disp_psrc2;
    t_data   disp_imm;
    t_preg   disp_pdst;
    logic    rs_stall;
    logic    alu_wr_en;
    t_preg   alu_wr_preg;
    t_data   alu_wr_data;
    logic    mul_wr_en;
    t_preg   mul_wr_preg;
    t_data   mul_wr_data;

    // Stimulus table
    int      row_test [$];
    int      row_cls  [$];
    t_uop    row_uop  [$];
    t_optype row_t1   [$];
    t_optype row_t2   [$];
    int      row_a1   [$];
    int      row_a2   [$];
    t_data   row_imm  [$];
    int      row_dst  [$];

    // Golden model per physical register
    t_preg   arch_map  [NUM_ARCH];
    t_data   gold_val  [NUM_PREGS];
    t_fu     gold_fu   [NUM_PREGS];
    bit      gold_wr   [NUM_PREGS];
    int      preg_test [NUM_PREGS];

    // Owned by the writeback monitor
    int      wr_count  [NUM_PREGS];
    int      mon_errors;
    int      checks;
    int      exec_writes;
    int      stall_cycles;

    int      seed;
    int      next_preg;
    t_preg   orphan_preg;
    int      exec_dispatched;
    int      errors;
    int      tests;
    int      start_errors;
    int      stall_mark;
    string   test_name [6];

    issue_top #(
        .NUM_RS_ENTS (NUM_ENTS)
    ) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .disp_valid     (disp_valid),
        .disp_uop       (disp_uop),
        .disp_src1_type (disp_src1_type),
        .disp_src2_type (disp_src2_type),
        .disp_psrc1     (disp_psrc1),
        .disp_psrc2     (disp_psrc2),
        .disp_imm       (disp_imm),
        .disp_pdst      (disp_pdst),
        .rs_stall       (rs_stall),
        .alu_wr_en      (alu_wr_en),
        .alu_wr_preg    (alu_wr_preg),
        .alu_wr_data    (alu_wr_data),
        .mul_wr_en      (mul_wr_en),
        .mul_wr_preg    (mul_wr_preg),
        .mul_wr_data    (mul_wr_data)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic t_data expect_result(t_uop uop, t_data a, t_data b);
        case (uop)
            UOP_ADD: return a + b;
            UOP_SUB: return a - b;
            UOP_AND: return a & b;
            UOP_XOR: return a ^ b;
            UOP_SLL: return a << b[4:0];
            default: return a * b;
        endcase
    endfunction

    function automatic t_data operand(t_optype kind, int areg, t_data imm);
        case (kind)
            OP_IMM:  return imm;
            OP_REG:  return gold_val[arch_map[areg]];
            default: return '0;
        endcase
    endfunction

    task automatic check_write(string name, t_fu fu, t_preg preg, t_data data);
        checks++;
        wr_count[preg]++;
        if (!gold_wr[preg]) begin
            mon_errors++;
            $display("unexpected writeback to p%0d on %s", preg, name);
        end else begin
            if (gold_fu[preg] != fu) begin
                mon_errors++;
                $display("p%0d written back by the wrong unit on %s", preg, name);
            end
            if (data != gold_val[preg]) begin
                mon_errors++;
                $display("MISMATCH %s p%0d: expected %08h, actual %08h",
                         name, preg, gold_val[preg], data);
            end
            if (wr_count[preg] == 1) begin
                exec_writes++;
            end
        end
    endtask

    // Sample writeback at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (rs_stall) begin
                stall_cycles++;
            end
            if (alu_wr_en) begin
                check_write("alu_wr_data", FU_ALU, alu_wr_preg, alu_wr_data);
            end
            if (mul_wr_en) begin
                check_write("mul_wr_data", FU_MUL, mul_wr_preg, mul_wr_data);
            end
        end
    end

    task automatic add_row(int test, int cls, t_uop uop, t_optype t1, t_optype t2,
                           int a1, int a2, t_data imm, int dst);
        row_test.push_back(test);
        row_cls.push_back(cls);
        row_uop.push_back(uop);
        row_t1.push_back(t1);
        row_t2.push_back(t2);
        row_a1.push_back(a1);
        row_a2.push_back(a2);
        row_imm.push_back(imm);
        row_dst.push_back(dst);
    endtask

    task automatic build_table();
        int i;
        add_row(1, CLS_EXEC, UOP_ADD, OP_IMM, OP_ZERO, 0, 0, $random(seed), 1);
        add_row(1, CLS_EXEC, UOP_SUB, OP_ZERO, OP_IMM, 0, 0, $random(seed), 2);
        add_row(1, CLS_EXEC, UOP_AND, OP_REG, OP_IMM, 1, 0, $random(seed), 3);
        add_row(1, CLS_EXEC, UOP_XOR, OP_REG, OP_IMM, 2, 0, $random(seed), 4);
        add_row(1, CLS_EXEC, UOP_SLL, OP_REG, OP_IMM, 1, 0, $random(seed), 5);
        add_row(2, CLS_EXEC, UOP_MUL, OP_REG, OP_IMM, 1, 0, $random(seed), 6);
        add_row(2, CLS_EXEC, UOP_MUL, OP_REG, OP_REG, 2, 4, '0, 7);
        // Mixed chain where the last row can overtake
        add_row(3, CLS_EXEC, UOP_MUL, OP_REG, OP_IMM, 3, 0, $random(seed), 1);
        add_row(3, CLS_EXEC, UOP_ADD, OP_REG, OP_REG, 1, 4, '0, 2);
        add_row(3, CLS_EXEC, UOP_MUL, OP_REG, OP_REG, 2, 1, '0, 3);
        add_row(3, CLS_EXEC, UOP_SUB, OP_REG, OP_IMM, 3, 0, $random(seed), 4);
        add_row(3, CLS_EXEC, UOP_XOR, OP_REG, OP_REG, 4, 2, '0, 5);
        add_row(3, CLS_EXEC, UOP_AND, OP_IMM, OP_REG, 0, 6, $random(seed), 6);
        // Slow multiply chain with a crowd behind it
        add_row(4, CLS_EXEC, UOP_MUL, OP_REG, OP_IMM, 5, 0, $random(seed), 1);
        add_row(4, CLS_EXEC, UOP_MUL, OP_REG, OP_IMM, 1, 0, $random(seed), 1);
        add_row(4, CLS_EXEC, UOP_MUL, OP_REG, OP_IMM, 1, 0, $random(seed), 7);
        for (i = 0; i < 10; i++) begin
            add_row(4, CLS_EXEC, t_uop'(i % 5), OP_REG, OP_IMM, 7, 0, $random(seed),
                    2 + i % 5);
        end
        // r7 is marked busy and its producer discarded
        add_row(5, CLS_ORPHAN, UOP_ADD, OP_IMM, OP_ZERO, 0, 0, $random(seed), 7);
        add_row(5, CLS_WAIT, UOP_ADD, OP_REG, OP_IMM, 7, 0, $random(seed), 6);
        add_row(5, CLS_WAIT, UOP_MUL, OP_REG, OP_REG, 7, 7, '0, 6);
        add_row(5, CLS_FLUSH, UOP_ADD, OP_ZERO, OP_ZERO, 0, 0, '0, 0);
        // Producing the orphan register wakes any entry the flush left behind
        add_row(5, CLS_REVIVE, UOP_ADD, OP_IMM, OP_ZERO, 0, 0, $random(seed), 7);
        add_row(5, CLS_EXEC, UOP_ADD, OP_REG, OP_IMM, 1, 0, $random(seed), 2);
        add_row(5, CLS_EXEC, UOP_MUL, OP_REG, OP_REG, 2, 3, '0, 4);
    endtask

    task automatic dispatch_row(int r);
        int    waited;
        t_preg pdst;
        t_data v1;
        t_data v2;
        waited = 0;
        while (rs_stall && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (rs_stall) begin
            errors++;
            $display("timeout: rs_stall never dropped before row %0d", r);
        end else if (row_cls[r] != CLS_REVIVE && next_preg >= NUM_PREGS) begin
            errors++;
            $display("out of physical registers at row %0d", r);
        end else begin
            if (row_cls[r] == CLS_REVIVE) begin
                pdst = orphan_preg;
            end else begin
                pdst = t_preg'(next_preg);
                next_preg++;
            end
            if (row_cls[r] == CLS_ORPHAN) begin
                orphan_preg = pdst;
            end
            v1 = operand(row_t1[r], row_a1[r], row_imm[r]);
            v2 = operand(row_t2[r], row_a2[r], row_imm[r]);
            gold_val[pdst]  = expect_result(row_uop[r], v1, v2);
            gold_fu[pdst]   = uop_to_fu(row_uop[r]);
            gold_wr[pdst]   = (row_cls[r] == CLS_EXEC || row_cls[r] == CLS_REVIVE);
            preg_test[pdst] = row_test[r];
            if (gold_wr[pdst]) begin
                exec_dispatched++;
            end
            disp_valid     = 1'b1;
            disp_uop       = row_uop[r];
            disp_src1_type = row_t1[r];
            disp_src2_type = row_t2[r];
            disp_psrc1     = arch_map[row_a1[r]];
            disp_psrc2     = arch_map[row_a2[r]];
            disp_imm       = row_imm[r];
            disp_pdst      = pdst;
            // An orphan goes in together with a flush
            flush          = (row_cls[r] == CLS_ORPHAN);
            arch_map[row_dst[r]] = pdst;
            @(posedge clk);
            #1;
            disp_valid = 1'b0;
            flush      = 1'b0;
        end
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    task automatic finish_test(int test);
        int waited;
        int p;
        waited = 0;
        while (exec_writes < exec_dispatched && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exec_writes < exec_dispatched) begin
            errors++;
            $display("timeout: %0d writebacks missing in test %0d",
                     exec_dispatched - exec_writes, test);
        end
        // Idle gap so a stray writeback would show up
        repeat (4) @(posedge clk);
        #1;
        for (p = 1; p < NUM_PREGS; p++) begin
            if (preg_test[p] == test && gold_wr[p] && wr_count[p] != 1) begin
                errors++;
                $display("p%0d written back %0d times instead of once", p, wr_count[p]);
            end
            if (preg_test[p] == test && !gold_wr[p] && wr_count[p] != 0) begin
                errors++;
                $display("discarded micro-op for p%0d was still written back", p);
            end
        end
        if (test == STALL_TEST && stall_cycles == stall_mark) begin
            errors++;
            $display("rs_stall never went high with the station full");
        end
        tests++;
        $display("test %0d %s: %s, %0d errors", test, test_name[test],
                 (errors + mon_errors == start_errors) ? "pass" : "FAIL",
                 errors + mon_errors - start_errors);
        start_errors = errors + mon_errors;
        stall_mark   = stall_cycles;
    endtask

    initial begin
        int r;
        int cur_test;
        seed            = 32'h34df_eda6;
        rst_n           = 1'b0;
        flush           = 1'b0;
        disp_valid      = 1'b0;
        disp_uop        = UOP_ADD;
        disp_src1_type  = OP_ZERO;
        disp_src2_type  = OP_ZERO;
        disp_psrc1      = '0;
        disp_psrc2      = '0;
        disp_imm        = '0;
        disp_pdst       = '0;
        next_preg       = 1;
        orphan_preg     = '0;
        exec_dispatched = 0;
        errors          = 0;
        tests           = 0;
        start_errors    = 0;
        stall_mark      = 0;
        test_name[0]    = "none";
        test_name[1]    = "alu immediates";
        test_name[2]    = "multiplies";
        test_name[3]    = "mixed chain";
        test_name[4]    = "full station";
        test_name[5]    = "flush";
        for (r = 0; r < NUM_ARCH; r++) begin
            arch_map[r] = '0;
        end
        for (r = 0; r < NUM_PREGS; r++) begin
            gold_val[r] = '0;
            gold_fu[r]  = FU_ALU;
        end
        build_table();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        cur_test = row_test[0];
        for (r = 0; r < row_test.size(); r++) begin
            if (row_test[r] != cur_test) begin
                finish_test(cur_test);
                cur_test = row_test[r];
            end
            if (row_cls[r] == CLS_FLUSH) begin
                pulse_flush();
            end else begin
                dispatch_row(r);
            end
        end
        finish_test(cur_test);
        $display("tests %0d, writeback checks %0d, errors %0d",
                 tests, checks, errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* files.f */
verilog/rs_pkg.sv
verilog/rs_entry.sv
verilog/rs.sv
verilog/prf.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/issue_top.sv
test/rs_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rs_tb -f files.f -o rs_sim || exit 1
out="$(./obj_dir/rs_sim 2>&1)"
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
